//--- dv/riscv_chk.sv
////////////////////////////////////////
// assertions on the core's top-level ports
// bound into riscv_top with ports matched by name
////////////////////////////////////////
`default_nettype none

module riscv_chk
(
    input wire risc_clk,
    input wire risc_rst,
    input wire instr_ready_o,
    input wire mem_rd_en_o,
    input wire mem_wr_en_o
);

    // one memory access per cycle at most
    rd_wr_excl: assert property (@(posedge risc_clk) disable iff (!risc_rst)
        !(mem_rd_en_o && mem_wr_en_o))
        else $error("memory read and write enables high in the same cycle");

    // load-use stall lasts a single cycle
    stall_one_cycle: assert property (@(posedge risc_clk) disable iff (!risc_rst)
        !instr_ready_o |=> instr_ready_o)
        else $error("instruction ready held low for two cycles");

    quiet_in_reset: assert property (@(posedge risc_clk)
        !risc_rst |-> (!mem_rd_en_o && !mem_wr_en_o))
        else $error("memory enable high during reset");

endmodule

bind riscv_top riscv_chk riscv_chk_i (.*);

`default_nettype wire

//--- dv/riscv_tb.sv
////////////////////////////////////////
// testbench for the 16-bit pipelined core
// lfsr instruction stream on valid/ready, a 64-word
// memory responder, and an instruction-level model
// with its own view of ir and id/ex for stall timing
////////////////////////////////////////
`default_nettype none

module riscv_tb
    import riscv_pkg::*;
();

    localparam int N_RANDOM    = 300;
    localparam int N_DUMP      = 32;             // one store per register
    localparam int N_DRAIN     = 12;             // four in flight plus slack
    localparam int CYCLE_LIMIT = 2 * (N_RANDOM + N_DUMP) + 40;

    logic               risc_clk;
    logic               risc_rst;
    logic               instr_valid_i;
    logic [INSTR_W-1:0] instr_i;
    logic               instr_ready_o;
    logic               mem_rd_en_o;
    logic               mem_wr_en_o;
    logic [DATA_W-1:0]  mem_addr_o;
    logic [DATA_W-1:0]  mem_wr_data_o;
    logic [DATA_W-1:0]  mem_rd_data_i;
    logic               carry_o;
    logic               zero_o;

    logic [15:0]        lfsr;
    logic [DATA_W-1:0]  tb_mem [64];             // responder storage
    logic [DATA_W-1:0]  model_mem [64];          // model's own copy
    logic [DATA_W-1:0]  model_regs [NUM_REGS];
    logic [63:0]        store_q [$];             // {addr, data}
    logic [DATA_W-1:0]  load_q [$];
    logic [1:0]         flag_q [$];              // {carry, zero}
    logic               m_ir_v;                  // model ir and id/ex
    logic [15:0]        m_ir_w;
    logic               m_ex_v;
    logic [15:0]        m_ex_w;
    logic               stall_pred;
    logic               last_acc;                // accepted at the coming edge
    logic [15:0]        last_word;
    logic               rd_pend;
    logic [DATA_W-1:0]  rd_word;
    int                 n_checks;
    int                 n_mismatch;
    int                 n_other;
    int                 cycle_cnt;

    riscv_top riscv_top_i (
        .risc_clk      (risc_clk),
        .risc_rst      (risc_rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .mem_rd_en_o   (mem_rd_en_o),
        .mem_wr_en_o   (mem_wr_en_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .mem_rd_data_i (mem_rd_data_i),
        .carry_o       (carry_o),
        .zero_o        (zero_o)
    );

    always #4 risc_clk = ~risc_clk;              // period 8

    //////////////// random source /////////////
    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        int          i;
        r = 32'd0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);              // one step per bit
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // registers x0..x7 only, so hazards come often
    function automatic logic [15:0] rand_instr();
        logic [31:0] op;
        logic [31:0] f;
        logic [31:0] a;
        logic [31:0] b;
        op = take_bits(2);
        f  = take_bits(3);
        a  = take_bits(3);
        b  = take_bits(3);
        return {f[2:0], 2'b00, a[2:0], 2'b00, b[2:0], 1'b0, op[1:0]};
    endfunction

    //////////////// reference model ///////////
    function automatic logic [DATA_W-1:0] reg_val(input logic [4:0] idx);
        return (idx == 5'd0) ? '0 : model_regs[idx];
    endfunction

    task automatic model_exec(input logic [15:0] w);
        logic [2:0]        f;
        logic [4:0]        a;                    // rd / rt
        logic [4:0]        b;                    // rs2 / base
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        logic [DATA_W:0]   wide;
        logic [DATA_W-1:0] res;
        logic [DATA_W-1:0] addr;
        logic              cy;
        f    = w[15:13];
        a    = w[12:8];
        b    = w[7:3];
        x    = reg_val(a);
        y    = reg_val(b);
        addr = y + {27'd0, f, 2'b00};            // off3 in words
        case (w[1:0])
            OP_ALU:
            begin
                wide = {1'b0, x} + {1'b0, y};    // spare codes add too
                res  = wide[DATA_W-1:0];
                cy   = wide[DATA_W];
                case (f)
                    FN_SUB:
                    begin
                        res = x - y;
                        cy  = (x >= y);          // unsigned no-borrow
                    end
                    FN_AND:
                    begin
                        res = x & y;
                        cy  = 1'b0;
                    end
                    FN_OR:
                    begin
                        res = x | y;
                        cy  = 1'b0;
                    end
                    FN_XOR:
                    begin
                        res = x ^ y;
                        cy  = 1'b0;
                    end
                    default: ;
                endcase
                if (a != 5'd0)
                    model_regs[a] = res;
                flag_q.push_back({cy, res == '0});
            end
            OP_LW:
            begin
                load_q.push_back(addr);
                if (a != 5'd0)
                    model_regs[a] = model_mem[addr[7:2]];
            end
            OP_SW:
            begin
                store_q.push_back({addr, x});
                model_mem[addr[7:2]] = x;
            end
            default:
            begin
                wide = {1'b0, y} + {30'd0, f};   // addi, off3 zero-extended
                res  = wide[DATA_W-1:0];
                if (a != 5'd0)
                    model_regs[a] = res;
                flag_q.push_back({wide[DATA_W], res == '0});
            end
        endcase
    endtask

    // ir reads the destination of a load sitting in id/ex
    function automatic logic load_use_hit(input logic [15:0] ir_w, input logic [15:0] ex_w);
        logic [4:0] d;
        logic [4:0] a;
        logic [4:0] b;
        logic       hit;
        d = ex_w[12:8];
        a = ir_w[12:8];
        b = ir_w[7:3];
        if (ex_w[1:0] != OP_LW || d == 5'd0)
            hit = 1'b0;
        else if (ir_w[1:0] == OP_ALU || ir_w[1:0] == OP_SW)
            hit = (a == d) || (b == d);          // both fields read
        else
            hit = (b == d);                      // base only
        return hit;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_mismatch++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    //////////////// per-cycle step ////////////
    // outputs are sampled 1 unit after the edge, inputs driven then too
    task automatic next_cycle();
        logic        moved_flags;
        logic [1:0]  exp_fl;
        logic [63:0] exp_st;
        @(posedge risc_clk);
        #1;
        // model pipeline takes the edge that just passed
        moved_flags = m_ex_v && (m_ex_w[1:0] == OP_ALU || m_ex_w[1:0] == OP_ADDI);
        m_ex_v = m_ir_v && !stall_pred;          // bubble behind a stall
        m_ex_w = m_ir_w;
        if (!stall_pred)
        begin
            m_ir_v = last_acc;
            m_ir_w = last_word;
        end
        last_acc = 1'b0;
        if (moved_flags)
        begin
            if (flag_q.size() == 0)
            begin
                n_other++;
                $display("flags updated with no ALU or ADDI result expected");
            end
            else
            begin
                exp_fl = flag_q.pop_front();
                compare_word("carry_o", {31'd0, carry_o}, {31'd0, exp_fl[1]});
                compare_word("zero_o", {31'd0, zero_o}, {31'd0, exp_fl[0]});
            end
        end
        // memory responder, read data one cycle after the request
        if (rd_pend)
            mem_rd_data_i = rd_word;
        rd_pend = 1'b0;
        if (mem_wr_en_o === 1'b1)
        begin
            if (store_q.size() == 0)
            begin
                n_other++;
                $display("memory write at %h while no store was expected", mem_addr_o);
            end
            else
            begin
                exp_st = store_q.pop_front();
                compare_word("mem_addr_o", mem_addr_o, exp_st[63:32]);
                compare_word("mem_wr_data_o", mem_wr_data_o, exp_st[31:0]);
            end
            tb_mem[mem_addr_o[7:2]] = mem_wr_data_o;
        end
        if (mem_rd_en_o === 1'b1)
        begin
            if (load_q.size() == 0)
            begin
                n_other++;
                $display("memory read at %h while no load was expected", mem_addr_o);
            end
            else
                compare_word("mem_addr_o", mem_addr_o, load_q.pop_front());
            rd_word = tb_mem[mem_addr_o[7:2]];
            rd_pend = 1'b1;
        end
        stall_pred = m_ir_v && m_ex_v && load_use_hit(m_ir_w, m_ex_w);
        compare_word("instr_ready_o", {31'd0, instr_ready_o}, {31'd0, !stall_pred});
    endtask

    task automatic idle_cycle();
        instr_valid_i = 1'b0;
        next_cycle();
    endtask

    // offer one instruction, held until ready
    task automatic send_instr(input logic [15:0] w);
        instr_valid_i = 1'b1;
        instr_i       = w;
        while (instr_ready_o !== 1'b1)
            next_cycle();
        last_acc  = 1'b1;
        last_word = w;
        model_exec(w);
        next_cycle();
        instr_valid_i = 1'b0;
    endtask

    task automatic finish_run();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 n_checks, n_mismatch, n_other);
        if (n_mismatch + n_other == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    //////////////// main sequence /////////////
    initial
    begin
        int n;
        risc_clk      = 1'b0;
        risc_rst      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        mem_rd_data_i = '0;
        n_checks      = 0;
        n_mismatch    = 0;
        n_other       = 0;
        lfsr          = 16'd25;
        m_ir_v        = 1'b0;
        m_ir_w        = '0;
        m_ex_v        = 1'b0;
        m_ex_w        = '0;
        stall_pred    = 1'b0;
        last_acc      = 1'b0;
        last_word     = '0;
        rd_pend       = 1'b0;
        rd_word       = '0;
        for (n = 0; n < NUM_REGS; n++)
            model_regs[n] = '0;
        for (n = 0; n < 64; n++)
        begin
            tb_mem[n]    = take_bits(32);
            model_mem[n] = tb_mem[n];
        end
        repeat (2) @(posedge risc_clk);
        #1;
        risc_rst = 1'b1;
        for (n = 0; n < N_RANDOM; n++)
        begin
            if (take_bits(2) == 32'd0)
                idle_cycle();                    // gap in the stream
            send_instr(rand_instr());
        end
        // dump x0..x31 to address 0
        for (n = 0; n < N_DUMP; n++)
            send_instr({3'b000, n[4:0], 5'd0, 1'b0, OP_SW});
        repeat (N_DRAIN) idle_cycle();
        if (store_q.size() != 0)
        begin
            n_other++;
            $display("%0d expected stores never reached the memory port", store_q.size());
        end
        if (load_q.size() != 0)
        begin
            n_other++;
            $display("%0d expected loads never reached the memory port", load_q.size());
        end
        if (flag_q.size() != 0)
        begin
            n_other++;
            $display("%0d expected flag updates never happened", flag_q.size());
        end
        finish_run();
    end

    // watchdog
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge risc_clk);
            cycle_cnt++;
        end
        n_other++;
        $display("run did not finish within %0d cycles", CYCLE_LIMIT);
        finish_run();
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/riscv_pkg.sv
verilog/riscv_if.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/riscv_top.sv
dv/riscv_chk.sv
dv/riscv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core and its testbench with verilator, run, and judge the output
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f filelist.f \
    --top-module riscv_tb \
    -o sim_riscv

out="$(./obj_dir/sim_riscv)"
echo "$out"

# a run counts as passed only when the testbench printed its pass line
echo "$out" | grep -qx "PASS: all tests"

//--- verilog/execute_stage.sv
////////////////////////////////////////
// execute stage of the core
// id/ex register, operand forwarding from ex/mem and
// write-back, the alu with carry/zero flags, and the
// ex/mem register that feeds the memory stage
////////////////////////////////////////
`default_nettype none

module execute_stage
    import riscv_pkg::*;
(
    input  wire                   risc_clk,
    input  wire                   risc_rst,
    input  wire                   wb_en_i,
    input  wire  [REG_ADDR_W-1:0] wb_rd_i,
    input  wire  [DATA_W-1:0]     wb_data_i,
    dec_bus_if.ex_mp              dec_i,
    output logic                  ex_is_load_o,    // to the hazard check
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    ex_mem_if.src_mp              exm_o,
    output logic                  carry_o,
    output logic                  zero_o
);

    logic                  idex_v;
    logic                  idex_alu;
    logic                  idex_load;
    logic                  idex_store;
    logic                  idex_addi;
    logic [2:0]            idex_funct;
    logic [REG_ADDR_W-1:0] idex_rd;
    logic [REG_ADDR_W-1:0] idex_rs1;
    logic [REG_ADDR_W-1:0] idex_rs2;
    logic [DATA_W-1:0]     idex_imm;
    logic [DATA_W-1:0]     idex_rs1_data;
    logic [DATA_W-1:0]     idex_rs2_data;
    logic [DATA_W-1:0]     op_a;
    logic [DATA_W-1:0]     op_b;
    logic [DATA_W-1:0]     alu_b;
    logic [DATA_W:0]       sum;           // bit DATA_W is carry out
    logic [DATA_W:0]       diff;
    logic [DATA_W-1:0]     result;
    logic                  carry;

    // ex/mem first, then write-back, else file value
    function automatic logic [DATA_W-1:0] fwd_sel(
        input logic [REG_ADDR_W-1:0] src,
        input logic [DATA_W-1:0]     rf_val
    );
        if (src == '0)
            return rf_val;
        else if (exm_o.mv && exm_o.wr_en && !exm_o.is_load && (exm_o.rd == src))
            return exm_o.result;          // load data not there yet
        else if (wb_en_i && (wb_rd_i == src))
            return wb_data_i;             // includes load data
        else
            return rf_val;
    endfunction

    //////////////// alu ///////////////////////
    always_comb
    begin
        op_a   = fwd_sel(idex_rs1, idex_rs1_data);
        op_b   = fwd_sel(idex_rs2, idex_rs2_data);
        alu_b  = idex_alu ? op_b : idex_imm;      // address or addi sum
        sum    = {1'b0, op_a} + {1'b0, alu_b};
        diff   = {1'b0, op_a} - {1'b0, alu_b};
        result = sum[DATA_W-1:0];
        carry  = sum[DATA_W];
        if (idex_alu)
        begin
            case (idex_funct)
                FN_SUB:
                begin
                    result = diff[DATA_W-1:0];
                    carry  = ~diff[DATA_W];       // no borrow, a >= b
                end
                FN_AND:
                begin
                    result = op_a & op_b;
                    carry  = 1'b0;
                end
                FN_OR:
                begin
                    result = op_a | op_b;
                    carry  = 1'b0;
                end
                FN_XOR:
                begin
                    result = op_a ^ op_b;
                    carry  = 1'b0;
                end
                default: ;                        // FN_ADD and spare codes
            endcase
        end
    end

    //////////////// pipeline control //////////
    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            idex_v         <= 1'b0;
            exm_o.mv       <= 1'b0;
            exm_o.is_load  <= 1'b0;
            exm_o.is_store <= 1'b0;
            exm_o.wr_en    <= 1'b0;
            carry_o        <= 1'b0;
            zero_o         <= 1'b0;
        end
        else
        begin
            idex_v         <= dec_i.dv;
            exm_o.mv       <= idex_v;
            exm_o.is_load  <= idex_v & idex_load;
            exm_o.is_store <= idex_v & idex_store;
            exm_o.wr_en    <= idex_v & ~idex_store;   // alu, lw, addi
            if (idex_v && (idex_alu || idex_addi))    // flags hold otherwise
            begin
                carry_o <= carry;
                zero_o  <= (result == '0);
            end
        end
    end

    // payload, qualified by the valid bits above
    always_ff @(posedge risc_clk)
    begin
        idex_alu      <= dec_i.is_alu;
        idex_load     <= dec_i.is_load;
        idex_store    <= dec_i.is_store;
        idex_addi     <= dec_i.is_addi;
        idex_funct    <= dec_i.funct;
        idex_rd       <= dec_i.rd;
        idex_rs1      <= dec_i.rs1;
        idex_rs2      <= dec_i.rs2;
        idex_imm      <= dec_i.imm;
        idex_rs1_data <= dec_i.rs1_data;
        idex_rs2_data <= dec_i.rs2_data;
        exm_o.rd      <= idex_rd;
        exm_o.result  <= result;
        exm_o.st_data <= op_b;          // forwarded rt for sw
    end

    assign ex_is_load_o = idex_v & idex_load;
    assign ex_rd_o      = idex_rd;

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
////////////////////////////////////////
// instruction register and decode stage
// takes instructions on a valid/ready pair, splits
// the fields, builds the immediate and reads the
// register file; holds one cycle on a load-use hit
////////////////////////////////////////
`default_nettype none

module instr_decoder
    import riscv_pkg::*;
(
    input  wire                   risc_clk,
    input  wire                   risc_rst,
    input  wire                   instr_valid_i,
    input  wire  [INSTR_W-1:0]    instr_i,
    output logic                  instr_ready_o,     // low only on stall
    input  wire                   ex_is_load_i,      // id/ex holds a load
    input  wire  [REG_ADDR_W-1:0] ex_rd_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  wire  [DATA_W-1:0]     rs1_data_i,
    input  wire  [DATA_W-1:0]     rs2_data_i,
    dec_bus_if.dec_mp             dec_o
);

    instr_u                ir;          // instruction register
    logic                  ir_valid;
    logic                  is_alu;
    logic                  is_load;
    logic                  is_store;
    logic                  is_addi;
    logic [REG_ADDR_W-1:0] src1;
    logic [REG_ADDR_W-1:0] src2;
    logic [REG_ADDR_W-1:0] dest;
    logic                  uses_src2;
    logic [DATA_W-1:0]     imm;
    logic                  stall;

    //////////////// ir capture ////////////////
    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            ir_valid <= 1'b0;
        end
        else if (instr_ready_o)
        begin
            ir_valid <= instr_valid_i;    // empty when source idles
        end
    end

    always_ff @(posedge risc_clk)
    begin
        if (instr_ready_o && instr_valid_i)
        begin
            ir <= instr_i;
        end
    end

    //////////////// field decode //////////////
    // op bits sit in the same place in both views
    assign is_alu   = (ir.r_view.op == OP_ALU);
    assign is_load  = (ir.m_view.op == OP_LW);
    assign is_store = (ir.m_view.op == OP_SW);
    assign is_addi  = (ir.m_view.op == OP_ADDI);

    assign src1      = is_alu ? ir.r_view.rd  : ir.m_view.base;
    assign src2      = is_alu ? ir.r_view.rs2 : ir.m_view.rt;    // rt is store data
    assign dest      = ir.m_view.rt;          // same bits as r_view.rd
    assign uses_src2 = is_alu | is_store;     // lw, addi read base only

    // addi takes off3 as is while lw/sw scale it to bytes
    assign imm = is_addi ? DATA_W'(ir.m_view.off3)
                         : DATA_W'(ir.m_view.off3) << WORD_SHIFT;

    //////////////// load-use check ////////////
    // load result is not back before this one reaches ex
    assign stall = ir_valid && ex_is_load_i && (ex_rd_i != '0) &&
                   ((src1 == ex_rd_i) || (uses_src2 && (src2 == ex_rd_i)));

    assign instr_ready_o = ~stall;

    assign rs1_addr_o = src1;
    assign rs2_addr_o = src2;

    // bubble into id/ex while held
    assign dec_o.dv       = ir_valid & ~stall;
    assign dec_o.is_alu   = is_alu;
    assign dec_o.is_load  = is_load;
    assign dec_o.is_store = is_store;
    assign dec_o.is_addi  = is_addi;
    assign dec_o.funct    = ir.r_view.funct;
    assign dec_o.rd       = dest;
    assign dec_o.rs1      = src1;
    assign dec_o.rs2      = src2;
    assign dec_o.imm      = imm;
    assign dec_o.rs1_data = rs1_data_i;
    assign dec_o.rs2_data = rs2_data_i;

endmodule

`default_nettype wire

//--- verilog/mem_wb_stage.sv
////////////////////////////////////////
// memory access and write-back stage
// drives the data memory port straight from ex/mem;
// read data comes back one cycle later while the
// instruction sits in mem/wb
////////////////////////////////////////
`default_nettype none

module mem_wb_stage
    import riscv_pkg::*;
(
    input  wire                   risc_clk,
    input  wire                   risc_rst,
    input  wire  [DATA_W-1:0]     mem_rd_data_i,    // valid the cycle after rd_en
    ex_mem_if.dst_mp              exm_i,
    output logic                  mem_rd_en_o,
    output logic                  mem_wr_en_o,
    output logic [DATA_W-1:0]     mem_addr_o,
    output logic [DATA_W-1:0]     mem_wr_data_o,
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [DATA_W-1:0]     wb_data_o
);

    logic                  mwb_wr;       // register write pending
    logic                  mwb_load;     // take data from memory
    logic [REG_ADDR_W-1:0] mwb_rd;
    logic [DATA_W-1:0]     mwb_result;

    // memory request, whole words only
    assign mem_rd_en_o   = exm_i.mv & exm_i.is_load;
    assign mem_wr_en_o   = exm_i.mv & exm_i.is_store;
    assign mem_addr_o    = exm_i.result;
    assign mem_wr_data_o = exm_i.st_data;

    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            mwb_wr   <= 1'b0;
            mwb_load <= 1'b0;
        end
        else
        begin
            mwb_wr   <= exm_i.mv & exm_i.wr_en;
            mwb_load <= exm_i.mv & exm_i.is_load;
        end
    end

    always_ff @(posedge risc_clk)
    begin
        mwb_rd     <= exm_i.rd;
        mwb_result <= exm_i.result;
    end

    // write-back bus, also the second forwarding source
    assign wb_en_o   = mwb_wr;
    assign wb_rd_o   = mwb_rd;
    assign wb_data_o = mwb_load ? mem_rd_data_i : mwb_result;

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
////////////////////////////////////////
// 32 x 32-bit register file, two read ports
// x0 reads zero; a write in flight shows up on
// the read ports in the same cycle
////////////////////////////////////////
`default_nettype none

module reg_file
    import riscv_pkg::*;
(
    input  wire                   risc_clk,
    input  wire                   risc_rst,
    input  wire  [REG_ADDR_W-1:0] rs1_addr_i,
    input  wire  [REG_ADDR_W-1:0] rs2_addr_i,
    input  wire                   wb_en_i,
    input  wire  [REG_ADDR_W-1:0] wb_rd_i,
    input  wire  [DATA_W-1:0]     wb_data_i,
    output logic [DATA_W-1:0]     rs1_data_o,
    output logic [DATA_W-1:0]     rs2_data_o
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // one read port, bypassing the pending write
    function automatic logic [DATA_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wb_en_i && (wb_rd_i == addr))
            return wb_data_i;             // write-through
        else
            return regs[addr];
    endfunction

    always_ff @(posedge risc_clk or negedge risc_rst)
    begin
        if (!risc_rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_en_i && (wb_rd_i != '0))    // x0 stays zero
        begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    always_comb
    begin
        rs1_data_o = read_reg(rs1_addr_i);
        rs2_data_o = read_reg(rs2_addr_i);
    end

endmodule

`default_nettype wire

//--- verilog/riscv_if.sv
////////////////////////////////////////
// inner pipeline buses of the core
// dec_bus_if runs decoder -> execute
// ex_mem_if carries the ex/mem register on to mem/wb
////////////////////////////////////////
`default_nettype none

interface dec_bus_if
    import riscv_pkg::*;
();
    logic                  dv;          // 0 is a bubble
    logic                  is_alu;
    logic                  is_load;
    logic                  is_store;
    logic                  is_addi;
    logic [2:0]            funct;
    logic [REG_ADDR_W-1:0] rd;          // destination
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [DATA_W-1:0]     imm;         // byte offset or addi value
    logic [DATA_W-1:0]     rs1_data;    // register file values
    logic [DATA_W-1:0]     rs2_data;

    modport dec_mp (output dv, is_alu, is_load, is_store, is_addi, funct,
                    rd, rs1, rs2, imm, rs1_data, rs2_data);
    modport ex_mp  (input  dv, is_alu, is_load, is_store, is_addi, funct,
                    rd, rs1, rs2, imm, rs1_data, rs2_data);
endinterface

interface ex_mem_if
    import riscv_pkg::*;
();
    logic                  mv;          // stage holds an instruction
    logic                  is_load;
    logic                  is_store;
    logic                  wr_en;       // writes rd at write-back
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     result;      // alu value or memory address
    logic [DATA_W-1:0]     st_data;

    modport src_mp (output mv, is_load, is_store, wr_en, rd, result, st_data);
    modport dst_mp (input  mv, is_load, is_store, wr_en, rd, result, st_data);
endinterface

`default_nettype wire

//--- verilog/riscv_pkg.sv
////////////////////////////////////////
// shared definitions for the 16-bit pipelined core
// widths, opcode and alu function codes, and the
// instruction word with its two field views
// rtl blocks pull these in by wildcard import
////////////////////////////////////////
`default_nettype none

package riscv_pkg;

    //////////////// sizes /////////////////
    localparam int DATA_W     = 32;     // datapath word
    localparam int INSTR_W    = 16;     // compressed instruction
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // opcode, instruction bits 1:0
    localparam logic [1:0] OP_ALU  = 2'b00;   // rd = rd op rs2
    localparam logic [1:0] OP_LW   = 2'b01;
    localparam logic [1:0] OP_SW   = 2'b10;
    localparam logic [1:0] OP_ADDI = 2'b11;   // rt = base + off3

    // alu funct, 101..111 fall back to add
    localparam logic [2:0] FN_ADD = 3'b000;
    localparam logic [2:0] FN_SUB = 3'b001;
    localparam logic [2:0] FN_AND = 3'b010;
    localparam logic [2:0] FN_OR  = 3'b011;
    localparam logic [2:0] FN_XOR = 3'b100;

    localparam int WORD_SHIFT = 2;   // off3 counts words

    // same 16 bits, read per opcode class
    typedef union packed {
        struct packed {
            logic [2:0]            funct;
            logic [REG_ADDR_W-1:0] rd;      // also first source
            logic [REG_ADDR_W-1:0] rs2;
            logic                  rsvd;
            logic [1:0]            op;
        } r_view;                           // alu format
        struct packed {
            logic [2:0]            off3;
            logic [REG_ADDR_W-1:0] rt;      // dest, or store source
            logic [REG_ADDR_W-1:0] base;
            logic                  rsvd;
            logic [1:0]            op;
        } m_view;                           // lw, sw, addi
    } instr_u;

endpackage

`default_nettype wire

//--- verilog/riscv_top.sv
////////////////////////////////////////
// top level of the five-stage 16-bit core
// instructions in on valid/ready, data memory on
// plain enable ports with one-cycle read latency
////////////////////////////////////////
`default_nettype none

module riscv_top
    import riscv_pkg::*;
(
    input  wire                risc_clk,
    input  wire                risc_rst,          // async, active low
    input  wire                instr_valid_i,
    input  wire  [INSTR_W-1:0] instr_i,
    output logic               instr_ready_o,
    output logic               mem_rd_en_o,
    output logic               mem_wr_en_o,
    output logic [DATA_W-1:0]  mem_addr_o,
    output logic [DATA_W-1:0]  mem_wr_data_o,
    input  wire  [DATA_W-1:0]  mem_rd_data_i,
    output logic               carry_o,
    output logic               zero_o
);

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [DATA_W-1:0]     rs1_data;
    logic [DATA_W-1:0]     rs2_data;
    logic                  ex_is_load;     // id/ex fields for the stall
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  wb_en;          // write-back bus
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [DATA_W-1:0]     wb_data;

    dec_bus_if dec_bus ();
    ex_mem_if  exm_bus ();

    //////////////// decode ////////////////////
    instr_decoder instr_decoder_inst (
        .risc_clk      (risc_clk),
        .risc_rst      (risc_rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .ex_is_load_i  (ex_is_load),
        .ex_rd_i       (ex_rd),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .dec_o         (dec_bus)
    );

    reg_file reg_file_inst (
        .risc_clk   (risc_clk),
        .risc_rst   (risc_rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_en_i    (wb_en),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    //////////////// execute ///////////////////
    execute_stage execute_stage_inst (
        .risc_clk     (risc_clk),
        .risc_rst     (risc_rst),
        .wb_en_i      (wb_en),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .dec_i        (dec_bus),
        .ex_is_load_o (ex_is_load),
        .ex_rd_o      (ex_rd),
        .exm_o        (exm_bus),
        .carry_o      (carry_o),
        .zero_o       (zero_o)
    );

    //////////////// memory, write-back ////////
    mem_wb_stage mem_wb_stage_inst (
        .risc_clk      (risc_clk),
        .risc_rst      (risc_rst),
        .mem_rd_data_i (mem_rd_data_i),
        .exm_i         (exm_bus),
        .mem_rd_en_o   (mem_rd_en_o),
        .mem_wr_en_o   (mem_wr_en_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .wb_en_o       (wb_en),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data)
    );

endmodule

`default_nettype wire
